//--- files.f
hdl/udp_echo_pkg.sv
hdl/echo_config_regs.sv
hdl/udp_port_filter.sv
hdl/echo_header_builder.sv
hdl/payload_fifo.sv
hdl/heartbeat_led.sv
hdl/udp_echo_top.sv
tb/tb_udp_echo.sv

//--- Makefile
TOP = tb_udp_echo

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f files.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f files.f --top-module $(TOP)
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "ALL TESTS PASSED"

clean:
	rm -rf obj_dir

//--- tb/tb_udp_echo.sv
`timescale 1ns/1ps

module tb_udp_echo;
    import udp_echo_pkg::*;

    localparam ip_addr_t  LOCAL_IP   = 32'hC0A8_0280;
    localparam udp_port_t ECHO_PORT  = 16'd1234;
    localparam logic [7:0] TTL       = 8'd64;
    localparam int        FIFO_DEPTH = 16;
    localparam int        LED_DIV    = 50;
    localparam int        ECHO_N     = 4;
    localparam int        DROP_N     = 3;
    localparam int        BP_N       = 5;
    localparam int        CFG_N      = 3;
    localparam int        SHORT_MAX  = 12;
    localparam int        LONG_MAX   = 40;
    localparam int        FRAMES_MAX = ECHO_N + DROP_N + BP_N + CFG_N;
    localparam int        BYTES_MAX  = (ECHO_N + DROP_N + CFG_N) * SHORT_MAX + BP_N * LONG_MAX;
    // Slowest ready pattern is about one beat in three
    localparam int        CYCLE_LIMIT = FRAMES_MAX * 40 + BYTES_MAX * 12 + 1000;

    logic       clk;
    logic       rst;
    logic       rx_hdr_valid_i;
    udp_hdr_t   rx_hdr_i;
    logic       rx_hdr_ready_o;
    logic       rx_pay_valid_i;
    axis_byte_t rx_pay_i;
    logic       rx_pay_ready_o;
    logic       tx_hdr_valid_o;
    udp_hdr_t   tx_hdr_o;
    logic       tx_hdr_ready_i;
    logic       tx_pay_valid_o;
    axis_byte_t tx_pay_o;
    logic       tx_pay_ready_i;
    logic       cfg_we_i;
    cfg_addr_t  cfg_addr_i;
    logic [31:0] cfg_wdata_i;
    logic       led_o;

    udp_hdr_t   exp_hdr_q[$];
    axis_byte_t exp_pay_q[$];
    ip_addr_t   cur_ip;
    udp_port_t  cur_port;
    logic [7:0] cur_ttl;
    int         rdy_pct;
    logic       dropping;
    logic       saw_stall;
    logic       led_prev;
    int         since_toggle;
    int         toggles;
    int         cyc;
    int         errors;
    int         led_errors;
    int         passed;
    int         failed;
    int         err0;

    udp_echo_top #(
        .LOCAL_IP_RST  (LOCAL_IP),
        .ECHO_PORT_RST (ECHO_PORT),
        .TTL_RST       (TTL),
        .FIFO_DEPTH    (FIFO_DEPTH),
        .LED_DIV       (LED_DIV)
    ) i_dut (
        .clk            (clk),
        .rst            (rst),
        .rx_hdr_valid_i (rx_hdr_valid_i),
        .rx_hdr_i       (rx_hdr_i),
        .rx_hdr_ready_o (rx_hdr_ready_o),
        .rx_pay_valid_i (rx_pay_valid_i),
        .rx_pay_i       (rx_pay_i),
        .rx_pay_ready_o (rx_pay_ready_o),
        .tx_hdr_valid_o (tx_hdr_valid_o),
        .tx_hdr_o       (tx_hdr_o),
        .tx_hdr_ready_i (tx_hdr_ready_i),
        .tx_pay_valid_o (tx_pay_valid_o),
        .tx_pay_o       (tx_pay_o),
        .tx_pay_ready_i (tx_pay_ready_i),
        .cfg_we_i       (cfg_we_i),
        .cfg_addr_i     (cfg_addr_i),
        .cfg_wdata_i    (cfg_wdata_i),
        .led_o          (led_o)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cyc = cyc + 1;
    end

    initial begin
        wait (cyc >= CYCLE_LIMIT);
        $display("Timeout: run stopped after %0d cycles with replies outstanding", cyc);
        $display("SOME TESTS FAILED");
        $finish;
    end

    // Reply expected for a header under the current configuration
    function automatic udp_hdr_t reply_of(input udp_hdr_t h);
        udp_hdr_t r;
        r.src_ip   = cur_ip;
        r.dst_ip   = h.src_ip;
        r.src_port = h.dst_port;
        r.dst_port = h.src_port;
        r.length   = h.length;
        r.ttl      = cur_ttl;
        return r;
    endfunction

    always @(negedge clk) begin
        tx_hdr_ready_i = ($urandom() % 100) < rdy_pct;
        tx_pay_ready_i = ($urandom() % 100) < rdy_pct;
    end

    always @(posedge clk) begin
        udp_hdr_t   exp_h;
        axis_byte_t exp_b;
        if (!rst && tx_hdr_valid_o && tx_hdr_ready_i) begin
            hdr_expected: assert (exp_hdr_q.size() > 0) else begin
                errors++;
                $display("Reply header sent at %0t ns with no frame waiting for one", $time);
            end
            if (exp_hdr_q.size() > 0) begin
                exp_h = exp_hdr_q.pop_front();
                hdr_value: assert (tx_hdr_o == exp_h) else begin
                    errors++;
                    $display("ERROR %0t: reply header %h, expected %h", $time, tx_hdr_o, exp_h);
                end
            end
        end
        if (!rst && tx_pay_valid_o && tx_pay_ready_i) begin
            pay_expected: assert (exp_pay_q.size() > 0) else begin
                errors++;
                $display("Payload byte sent at %0t ns that no frame should echo", $time);
            end
            if (exp_pay_q.size() > 0) begin
                exp_b = exp_pay_q.pop_front();
                pay_value: assert (tx_pay_o == exp_b) else begin
                    errors++;
                    $display("ERROR %0t: payload beat %h, expected %h", $time, tx_pay_o, exp_b);
                end
            end
        end
        if (!rst && rx_pay_valid_i && !rx_pay_ready_o) begin
            saw_stall = 1'b1;
        end
    end

    hdr_hold: assert property (@(posedge clk) disable iff (rst)
        tx_hdr_valid_o && !tx_hdr_ready_i |=> tx_hdr_valid_o && $stable(tx_hdr_o))
    else begin
        errors++;
        $display("ERROR %0t: tx_hdr valid or data changed before transfer", $time);
    end

    pay_hold: assert property (@(posedge clk) disable iff (rst)
        tx_pay_valid_o && !tx_pay_ready_i |=> tx_pay_valid_o && $stable(tx_pay_o))
    else begin
        errors++;
        $display("ERROR %0t: tx_pay valid or data changed before transfer", $time);
    end

    drop_drain: assert property (@(posedge clk) disable iff (rst)
        dropping && rx_pay_valid_i |-> rx_pay_ready_o)
    else begin
        errors++;
        $display("ERROR %0t: rx_pay_ready_o low on a dropped frame", $time);
    end

    always @(posedge clk) begin
        if (rst) begin
            led_prev     = 1'b0;
            // A flip of led_o is seen one edge after it happens
            since_toggle = -1;
        end else begin
            since_toggle = since_toggle + 1;
            if (led_o != led_prev) begin
                led_period: assert (since_toggle == LED_DIV) else begin
                    led_errors++;
                    $display("ERROR %0t: led_o toggled after %0d cycles, expected %0d",
                             $time, since_toggle, LED_DIV);
                end
                since_toggle = 0;
                led_prev     = led_o;
                toggles      = toggles + 1;
            end
        end
    end

    task automatic send_frame(input udp_port_t dport, input int nbytes);
        udp_hdr_t   h;
        axis_byte_t b;
        logic       kept;
        h.src_ip   = $urandom();
        h.dst_ip   = cur_ip;
        h.src_port = 16'($urandom());
        h.dst_port = dport;
        h.length   = 16'(8 + nbytes);
        h.ttl      = 8'($urandom_range(1, 255));
        kept = dport == cur_port;
        if (kept) begin
            exp_hdr_q.push_back(reply_of(h));
        end
        @(negedge clk);
        rx_hdr_valid_i = 1'b1;
        rx_hdr_i       = h;
        @(posedge clk);
        while (!rx_hdr_ready_o) @(posedge clk);
        @(negedge clk);
        rx_hdr_valid_i = 1'b0;
        dropping       = !kept;
        for (int i = 0; i < nbytes; i++) begin
            b.data = 8'($urandom());
            b.last = i == nbytes - 1;
            b.user = ($urandom() % 8) == 0;
            if (kept) begin
                exp_pay_q.push_back(b);
            end
            rx_pay_valid_i = 1'b1;
            rx_pay_i       = b;
            @(posedge clk);
            while (!rx_pay_ready_o) @(posedge clk);
            @(negedge clk);
        end
        rx_pay_valid_i = 1'b0;
        dropping       = 1'b0;
    endtask

    task automatic write_cfg(input cfg_addr_t addr, input logic [31:0] data);
        @(negedge clk);
        cfg_we_i    = 1'b1;
        cfg_addr_i  = addr;
        cfg_wdata_i = data;
        @(negedge clk);
        cfg_we_i = 1'b0;
    endtask

    // Let every expected reply leave, then watch for stray output
    task automatic drain();
        while (exp_hdr_q.size() != 0 || exp_pay_q.size() != 0) @(negedge clk);
        repeat (20) @(negedge clk);
    endtask

    task automatic end_test(input string name, input logic ok);
        if (ok) begin
            passed++;
            $display("%s: pass", name);
        end else begin
            failed++;
            $display("%s: fail", name);
        end
    endtask

    initial begin
        void'($urandom(32'h96f3dc81));
        rst            = 1'b1;
        rx_hdr_valid_i = 1'b0;
        rx_hdr_i       = '0;
        rx_pay_valid_i = 1'b0;
        rx_pay_i       = '0;
        tx_hdr_ready_i = 1'b1;
        tx_pay_ready_i = 1'b1;
        cfg_we_i       = 1'b0;
        cfg_addr_i     = '0;
        cfg_wdata_i    = '0;
        cur_ip         = LOCAL_IP;
        cur_port       = ECHO_PORT;
        cur_ttl        = TTL;
        rdy_pct        = 100;
        dropping       = 1'b0;
        saw_stall      = 1'b0;
        toggles        = 0;
        cyc            = 0;
        errors         = 0;
        led_errors     = 0;
        passed         = 0;
        failed         = 0;
        repeat (3) @(negedge clk);
        rst = 1'b0;

        err0 = errors;
        reset_state: assert (!tx_hdr_valid_o && !tx_pay_valid_o && !led_o &&
                             rx_hdr_ready_o && !rx_pay_ready_o) else begin
            errors++;
            $display("ERROR %0t: outputs not in their reset state", $time);
        end
        end_test("reset state", errors == err0);

        err0 = errors;
        for (int i = 0; i < ECHO_N; i++) begin
            send_frame(cur_port, $urandom_range(1, SHORT_MAX));
        end
        drain();
        end_test("echo", errors == err0);

        err0 = errors;
        for (int i = 0; i < DROP_N; i++) begin
            send_frame(cur_port + 16'd1 + 16'($urandom_range(0, 99)),
                       $urandom_range(1, SHORT_MAX));
        end
        drain();
        end_test("drop", errors == err0);

        // Long frames against a slow reader fill the FIFO
        err0      = errors;
        rdy_pct   = 30;
        saw_stall = 1'b0;
        for (int i = 0; i < BP_N; i++) begin
            send_frame(cur_port, $urandom_range(FIFO_DEPTH + 4, LONG_MAX));
        end
        drain();
        fifo_stall: assert (saw_stall) else begin
            errors++;
            $display("rx_pay_ready_o never dropped although the FIFO should have filled");
        end
        rdy_pct = 100;
        end_test("back-pressure", errors == err0);

        err0 = errors;
        write_cfg(CFG_ADDR_ECHO_PORT, 32'd4321);
        write_cfg(CFG_ADDR_LOCAL_IP, 32'h0A00_0005);
        write_cfg(CFG_ADDR_TTL, 32'd32);
        cur_port = 16'd4321;
        cur_ip   = 32'h0A00_0005;
        cur_ttl  = 8'd32;
        rdy_pct  = 60;
        send_frame(16'd4321, $urandom_range(1, SHORT_MAX));
        send_frame(ECHO_PORT, $urandom_range(1, SHORT_MAX));
        send_frame(16'd4321, $urandom_range(1, SHORT_MAX));
        drain();
        rdy_pct = 100;
        end_test("configuration", errors == err0);

        while (toggles < 3) @(negedge clk);
        end_test("heartbeat", led_errors == 0);

        $display("Tests: %0d passed, %0d failed", passed, failed);
        if (failed == 0 && errors == 0 && led_errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- hdl/udp_echo_top.sv
`timescale 1ns/1ps

module udp_echo_top #(
    parameter udp_echo_pkg::ip_addr_t  LOCAL_IP_RST  = 32'hC0A8_0280,
    parameter udp_echo_pkg::udp_port_t ECHO_PORT_RST = 16'd1234,
    parameter logic [7:0]              TTL_RST       = 8'd64,
    parameter int                      FIFO_DEPTH    = 16,
    parameter int                      LED_DIV       = 12_500_000
) (
    input  logic                     clk,
    input  logic                     rst,

    input  logic                     rx_hdr_valid_i,
    input  udp_echo_pkg::udp_hdr_t   rx_hdr_i,
    output logic                     rx_hdr_ready_o,

    input  logic                     rx_pay_valid_i,
    input  udp_echo_pkg::axis_byte_t rx_pay_i,
    output logic                     rx_pay_ready_o,

    output logic                     tx_hdr_valid_o,
    output udp_echo_pkg::udp_hdr_t   tx_hdr_o,
    input  logic                     tx_hdr_ready_i,

    output logic                     tx_pay_valid_o,
    output udp_echo_pkg::axis_byte_t tx_pay_o,
    input  logic                     tx_pay_ready_i,

    input  logic                     cfg_we_i,
    input  udp_echo_pkg::cfg_addr_t  cfg_addr_i,
    input  logic [31:0]              cfg_wdata_i,

    output logic                     led_o
);
    import udp_echo_pkg::*;

    echo_cfg_t  cfg;

    logic       match_hdr_valid;
    udp_hdr_t   match_hdr;
    logic       match_hdr_ready;

    logic       keep_pay_valid;
    axis_byte_t keep_pay;
    logic       keep_pay_ready;

    echo_config_regs #(
        .LOCAL_IP_RST  (LOCAL_IP_RST),
        .ECHO_PORT_RST (ECHO_PORT_RST),
        .TTL_RST       (TTL_RST)
    ) i_cfg (
        .clk         (clk),
        .rst         (rst),
        .cfg_we_i    (cfg_we_i),
        .cfg_addr_i  (cfg_addr_i),
        .cfg_wdata_i (cfg_wdata_i),
        .cfg_o       (cfg)
    );

    udp_port_filter i_filter (
        .clk               (clk),
        .rst               (rst),
        .echo_port_i       (cfg.echo_port),
        .rx_hdr_valid_i    (rx_hdr_valid_i),
        .rx_hdr_i          (rx_hdr_i),
        .rx_hdr_ready_o    (rx_hdr_ready_o),
        .rx_pay_valid_i    (rx_pay_valid_i),
        .rx_pay_i          (rx_pay_i),
        .rx_pay_ready_o    (rx_pay_ready_o),
        .match_hdr_valid_o (match_hdr_valid),
        .match_hdr_o       (match_hdr),
        .match_hdr_ready_i (match_hdr_ready),
        .keep_pay_valid_o  (keep_pay_valid),
        .keep_pay_o        (keep_pay),
        .keep_pay_ready_i  (keep_pay_ready)
    );

    echo_header_builder i_hdr (
        .clk         (clk),
        .rst         (rst),
        .cfg_i       (cfg),
        .in_valid_i  (match_hdr_valid),
        .in_hdr_i    (match_hdr),
        .in_ready_o  (match_hdr_ready),
        .out_valid_o (tx_hdr_valid_o),
        .out_hdr_o   (tx_hdr_o),
        .out_ready_i (tx_hdr_ready_i)
    );

    payload_fifo #(
        .DEPTH (FIFO_DEPTH)
    ) i_fifo (
        .clk        (clk),
        .rst        (rst),
        .wr_valid_i (keep_pay_valid),
        .wr_data_i  (keep_pay),
        .wr_ready_o (keep_pay_ready),
        .rd_valid_o (tx_pay_valid_o),
        .rd_data_o  (tx_pay_o),
        .rd_ready_i (tx_pay_ready_i)
    );

    heartbeat_led #(
        .LED_DIV (LED_DIV)
    ) i_led (
        .clk   (clk),
        .rst   (rst),
        .led_o (led_o)
    );

endmodule

//--- hdl/heartbeat_led.sv
`timescale 1ns/1ps

module heartbeat_led #(
    parameter int LED_DIV = 12_500_000
) (
    input  logic clk,
    input  logic rst,
    output logic led_o
);
    localparam int CW = (LED_DIV > 1) ? $clog2(LED_DIV) : 1;
    localparam logic [CW-1:0] CNT_MAX = CW'(LED_DIV - 1);

    logic [CW-1:0] cnt;
    logic          cnt_end;

    assign cnt_end = cnt == CNT_MAX;

    always_ff @(posedge clk) begin
        if (rst) begin
            cnt   <= '0;
            led_o <= 1'b0;
        end else if (cnt_end) begin
            cnt   <= '0;
            led_o <= ~led_o;
        end else begin
            cnt <= cnt + 1'b1;
        end
    end

endmodule

//--- hdl/payload_fifo.sv
`timescale 1ns/1ps

module payload_fifo #(
    parameter int DEPTH = 16
) (
    input  logic                     clk,
    input  logic                     rst,

    input  logic                     wr_valid_i,
    input  udp_echo_pkg::axis_byte_t wr_data_i,
    output logic                     wr_ready_o,

    output logic                     rd_valid_o,
    output udp_echo_pkg::axis_byte_t rd_data_o,
    input  logic                     rd_ready_i
);
    import udp_echo_pkg::*;

    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CW = $clog2(DEPTH + 1);
    localparam logic [AW-1:0] LAST_PTR = AW'(DEPTH - 1);
    localparam logic [CW-1:0] FULL_CNT = CW'(DEPTH);

    axis_byte_t    mem [DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [CW-1:0] count;
    axis_byte_t    out_q;
    logic          out_valid;

    logic wr_fire;
    logic load_out;
    logic bypass;
    logic push;
    logic pop;

    assign wr_ready_o = count != FULL_CNT;
    assign rd_valid_o = out_valid;
    assign rd_data_o  = out_q;

    assign wr_fire  = wr_valid_i && wr_ready_o;
    assign load_out = !out_valid || rd_ready_i;
    // Empty buffer, write goes straight to the output stage
    assign bypass   = wr_fire && load_out && (count == '0);
    assign push     = wr_fire && !bypass;
    assign pop      = load_out && (count != '0);

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            count     <= '0;
            out_valid <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == LAST_PTR) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == LAST_PTR) ? '0 : rd_ptr + 1'b1;
            end
            count <= count + CW'(push) - CW'(pop);
            if (load_out) begin
                out_valid <= pop || bypass;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= wr_data_i;
        end
        if (pop) begin
            out_q <= mem[rd_ptr];
        end else if (bypass) begin
            out_q <= wr_data_i;
        end
    end

endmodule

//--- hdl/echo_header_builder.sv
`timescale 1ns/1ps

module echo_header_builder (
    input  logic                    clk,
    input  logic                    rst,
    input  udp_echo_pkg::echo_cfg_t cfg_i,

    input  logic                    in_valid_i,
    input  udp_echo_pkg::udp_hdr_t  in_hdr_i,
    output logic                    in_ready_o,

    output logic                    out_valid_o,
    output udp_echo_pkg::udp_hdr_t  out_hdr_o,
    input  logic                    out_ready_i
);
    import udp_echo_pkg::*;

    udp_hdr_t reply_d;
    udp_hdr_t hdr_q;
    logic     valid_q;

    // Turn the received header around
    always_comb begin
        reply_d          = in_hdr_i;
        reply_d.src_ip   = cfg_i.local_ip;
        reply_d.dst_ip   = in_hdr_i.src_ip;
        reply_d.src_port = in_hdr_i.dst_port;
        reply_d.dst_port = in_hdr_i.src_port;
        reply_d.ttl      = cfg_i.ttl;
    end

    assign in_ready_o  = !valid_q || out_ready_i;
    assign out_valid_o = valid_q;
    assign out_hdr_o   = hdr_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= 1'b0;
        end else if (in_valid_i && in_ready_o) begin
            valid_q <= 1'b1;
        end else if (out_ready_i) begin
            valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid_i && in_ready_o) begin
            hdr_q <= reply_d;
        end
    end

endmodule

//--- hdl/udp_port_filter.sv
`timescale 1ns/1ps

module udp_port_filter (
    input  logic                     clk,
    input  logic                     rst,
    input  udp_echo_pkg::udp_port_t  echo_port_i,

    input  logic                     rx_hdr_valid_i,
    input  udp_echo_pkg::udp_hdr_t   rx_hdr_i,
    output logic                     rx_hdr_ready_o,

    input  logic                     rx_pay_valid_i,
    input  udp_echo_pkg::axis_byte_t rx_pay_i,
    output logic                     rx_pay_ready_o,

    output logic                     match_hdr_valid_o,
    output udp_echo_pkg::udp_hdr_t   match_hdr_o,
    input  logic                     match_hdr_ready_i,

    output logic                     keep_pay_valid_o,
    output udp_echo_pkg::axis_byte_t keep_pay_o,
    input  logic                     keep_pay_ready_i
);
    logic frame_open;
    logic keep;
    logic hdr_match;
    logic hdr_fire;
    logic pay_fire;

    assign hdr_match = rx_hdr_i.dst_port == echo_port_i;

    // Headers only while no frame is open, dropped ones are swallowed
    assign rx_hdr_ready_o    = !frame_open && (hdr_match ? match_hdr_ready_i : 1'b1);
    assign match_hdr_valid_o = rx_hdr_valid_i && !frame_open && hdr_match;
    assign match_hdr_o       = rx_hdr_i;

    // Payload of a kept frame goes to the FIFO, dropped payload drains at full rate
    assign keep_pay_valid_o = rx_pay_valid_i && frame_open && keep;
    assign keep_pay_o       = rx_pay_i;
    assign rx_pay_ready_o   = frame_open && (keep ? keep_pay_ready_i : 1'b1);

    assign hdr_fire = rx_hdr_valid_i && rx_hdr_ready_o;
    assign pay_fire = rx_pay_valid_i && rx_pay_ready_o;

    always_ff @(posedge clk) begin
        if (rst) begin
            frame_open <= 1'b0;
            keep       <= 1'b0;
        end else if (hdr_fire) begin
            frame_open <= 1'b1;
            keep       <= hdr_match;
        end else if (pay_fire && rx_pay_i.last) begin
            frame_open <= 1'b0;
        end
    end

endmodule

//--- hdl/echo_config_regs.sv
`timescale 1ns/1ps

module echo_config_regs #(
    parameter udp_echo_pkg::ip_addr_t  LOCAL_IP_RST  = 32'hC0A8_0280,
    parameter udp_echo_pkg::udp_port_t ECHO_PORT_RST = 16'd1234,
    parameter logic [7:0]              TTL_RST       = 8'd64
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    cfg_we_i,
    input  udp_echo_pkg::cfg_addr_t cfg_addr_i,
    input  logic [31:0]             cfg_wdata_i,
    output udp_echo_pkg::echo_cfg_t cfg_o
);
    import udp_echo_pkg::*;

    always_ff @(posedge clk) begin
        if (rst) begin
            cfg_o.local_ip  <= LOCAL_IP_RST;
            cfg_o.echo_port <= ECHO_PORT_RST;
            cfg_o.ttl       <= TTL_RST;
        end else if (cfg_we_i) begin
            case (cfg_addr_i)
                CFG_ADDR_LOCAL_IP: begin
                    cfg_o.local_ip <= cfg_wdata_i[IP_W-1:0];
                end
                CFG_ADDR_ECHO_PORT: begin
                    cfg_o.echo_port <= cfg_wdata_i[PORT_W-1:0];
                end
                CFG_ADDR_TTL: begin
                    cfg_o.ttl <= cfg_wdata_i[TTL_W-1:0];
                end
                default: begin
                    // unmapped address, write dropped
                end
            endcase
        end
    end

endmodule

//--- hdl/udp_echo_pkg.sv
package udp_echo_pkg;

    // Header field widths
    localparam int IP_W   = 32;
    localparam int PORT_W = 16;
    localparam int LEN_W  = 16;
    localparam int TTL_W  = 8;

    typedef logic [IP_W-1:0]   ip_addr_t;
    typedef logic [PORT_W-1:0] udp_port_t;

    // Decoded UDP header, used for both directions
    typedef struct packed {
        ip_addr_t         src_ip;
        ip_addr_t         dst_ip;
        udp_port_t        src_port;
        udp_port_t        dst_port;
        logic [LEN_W-1:0] length;
        logic [TTL_W-1:0] ttl;
    } udp_hdr_t;

    // One payload beat
    typedef struct packed {
        logic [7:0] data;
        logic       last;
        logic       user;
    } axis_byte_t;

    // Configuration in force
    typedef struct packed {
        ip_addr_t         local_ip;
        udp_port_t        echo_port;
        logic [TTL_W-1:0] ttl;
    } echo_cfg_t;

    typedef logic [1:0] cfg_addr_t;

    // Configuration register map, address 3 is unused
    localparam cfg_addr_t CFG_ADDR_LOCAL_IP  = 2'd0;
    localparam cfg_addr_t CFG_ADDR_ECHO_PORT = 2'd1;
    localparam cfg_addr_t CFG_ADDR_TTL       = 2'd2;

endpackage
